//--- Bender.yml
package:
  name: team_top

sources:
  # Package first, then the RTL in dependency order
  - design/team_pkg.sv
  - design/wb_interconnect.sv
  - design/team_design.sv
  - design/la_control.sv
  - design/gpio_control.sv
  - design/team_top.sv

  # Testbench and bound checker
  - target: simulation
    files:
      - testbench/team_top_checker.sv
      - testbench/team_top_tb.sv

//--- design/gpio_control.sv
// GPIO pin owner select with per-pin software force
// Outputs only: no output enables and no input path
// Forced pins take the force value regardless of the owner

`timescale 1ns/1ps

module gpio_control
    import team_pkg::*;
#(
    parameter int NUM_TEAMS = 3
) (
    input  logic      wb_clk_i,
    input  logic      rst_i,

    // Wishbone slave
    input  logic      stb_i,
    input  logic      we_i,
    input  wb_addr_t  adr_i,
    input  wb_data_t  dat_i,
    output logic      ack_o,
    output wb_data_t  dat_o,

    // Team GPIO buses and chip pins
    input  gpio_bus_t team_gpio_i [NUM_TEAMS:1],
    output gpio_bus_t gpio_o
);

    team_idx_t gpio_owner;
    gpio_bus_t force_mask;
    gpio_bus_t force_value;
    gpio_bus_t owner_pins;
    logic      access;

    assign access = stb_i && !ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            gpio_owner  <= '0;
            force_mask  <= '0;
            force_value <= '0;
        end else if (access && we_i) begin
            case (adr_i[15:0])
                REG_GPIO_OWNER: gpio_owner  <= dat_i[7:0];
                REG_GPIO_MASK:  force_mask  <= dat_i[15:0];
                REG_GPIO_VALUE: force_value <= dat_i[15:0];
                default:        ;
            endcase
        end
    end

    // Owner's pins, zero when no valid owner
    always_comb begin
        owner_pins = '0;
        for (int i = 1; i <= NUM_TEAMS; i++) begin
            if (gpio_owner == team_idx_t'(i)) begin
                owner_pins = team_gpio_i[i];
            end
        end
    end

    // Mask bit set means the pin is forced
    assign gpio_o = (force_mask & force_value) | (~force_mask & owner_pins);

    always_comb begin
        case (adr_i[15:0])
            REG_GPIO_OWNER: dat_o = {24'h000000, gpio_owner};
            REG_GPIO_MASK:  dat_o = {16'h0000, force_mask};
            REG_GPIO_VALUE: dat_o = {16'h0000, force_value};
            default:        dat_o = '0;
        endcase
    end

endmodule

//--- design/la_control.sv
// Logic-analyzer output select with a one-cycle-delayed snapshot
// A select of 0 or above NUM_TEAMS drives zero on the LA outputs
// Only the low 8 bits of a select write are kept

`timescale 1ns/1ps

module la_control
    import team_pkg::*;
#(
    parameter int NUM_TEAMS = 3
) (
    input  logic     wb_clk_i,
    input  logic     rst_i,

    // Wishbone slave
    input  logic     stb_i,
    input  logic     we_i,
    input  wb_addr_t adr_i,
    input  wb_data_t dat_i,
    output logic     ack_o,
    output wb_data_t dat_o,

    // Team LA buses and chip output
    input  la_bus_t  team_la_i [NUM_TEAMS:1],
    output la_bus_t  la_data_o
);

    team_idx_t la_sel;
    la_bus_t   la_snap;
    logic      access;

    assign access = stb_i && !ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

    // Select register, snapshot is not writable
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            la_sel <= '0;
        end else if (access && we_i && adr_i[15:0] == REG_LA_SEL) begin
            la_sel <= dat_i[7:0];
        end
    end

    // Sampled every cycle, so reads lag the live bus by one edge
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            la_snap <= '0;
        end else begin
            la_snap <= la_data_o;
        end
    end

    // Output mux, out-of-range select falls through to zero
    always_comb begin
        la_data_o = '0;
        for (int i = 1; i <= NUM_TEAMS; i++) begin
            if (la_sel == team_idx_t'(i)) begin
                la_data_o = team_la_i[i];
            end
        end
    end

    always_comb begin
        case (adr_i[15:0])
            REG_LA_SEL:  dat_o = {24'h000000, la_sel};
            REG_LA_SNAP: dat_o = la_snap;
            default:     dat_o = '0;
        endcase
    end

endmodule

//--- design/team_design.sv
// Example team block: scratch, control, free-running counter and team ID
// Byte selects are ignored, every write is a full 32-bit write
// COUNT and ID are read-only; unused offsets read zero but still ack

`timescale 1ns/1ps

module team_design
    import team_pkg::*;
#(
    parameter team_idx_t TEAM_ID = 8'd1
) (
    input  logic      wb_clk_i,
    input  logic      rst_i,

    // Wishbone slave
    input  logic      stb_i,
    input  logic      we_i,
    input  wb_addr_t  adr_i,
    input  wb_data_t  dat_i,
    output logic      ack_o,
    output wb_data_t  dat_o,

    // Peripheral buses
    output la_bus_t   la_data_o,
    output gpio_bus_t gpio_o
);

    wb_data_t scratch;
    wb_data_t ctrl;
    wb_data_t count;
    logic     access;

    // First strobed edge only, so ack lasts one cycle
    assign access = stb_i && !ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            scratch <= '0;
            ctrl    <= '0;
        end else if (access && we_i) begin
            case (adr_i[15:0])
                REG_SCRATCH: scratch <= dat_i;
                REG_CTRL:    ctrl    <= dat_i;
                default:     ;
            endcase
        end
    end

    // CTRL bit 0 enables counting
    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            count <= '0;
        end else if (ctrl[0]) begin
            count <= count + 1'b1;
        end
    end

    // Read mux follows the held address
    always_comb begin
        case (adr_i[15:0])
            REG_SCRATCH: dat_o = scratch;
            REG_CTRL:    dat_o = ctrl;
            REG_COUNT:   dat_o = count;
            REG_ID:      dat_o = {24'h000000, TEAM_ID};
            default:     dat_o = '0;
        endcase
    end

    assign la_data_o = count;
    assign gpio_o    = scratch[15:0];

endmodule

//--- design/team_pkg.sv
// Shared widths and address map for the multi-team user area
// Team pages are 0x30NN with NN from 1 upwards; team 0 is never decoded
// Slaves decode only the low 16 address bits

package team_pkg;

    // Bus widths
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [31:0] la_bus_t;
    typedef logic [15:0] gpio_bus_t;

    // 0 means no team, 1..NUM_TEAMS are real teams
    typedef logic [7:0] team_idx_t;

    // Address pages, compared against wbs_adr_i[31:16]
    localparam logic [7:0]  DESIGN_PREFIX = 8'h30;
    localparam logic [15:0] LA_PAGE       = 16'h3100;
    localparam logic [15:0] GPIO_PAGE     = 16'h3200;

    // Team register offsets
    localparam logic [15:0] REG_SCRATCH = 16'h0000;
    localparam logic [15:0] REG_CTRL    = 16'h0004;
    localparam logic [15:0] REG_COUNT   = 16'h0008;
    localparam logic [15:0] REG_ID      = 16'h000C;

    // LA control offsets
    localparam logic [15:0] REG_LA_SEL  = 16'h0000;
    localparam logic [15:0] REG_LA_SNAP = 16'h0004;

    // GPIO control offsets
    localparam logic [15:0] REG_GPIO_OWNER = 16'h0000;
    localparam logic [15:0] REG_GPIO_MASK  = 16'h0004;
    localparam logic [15:0] REG_GPIO_VALUE = 16'h0008;

endpackage

//--- design/team_top.sv
// User-area top: interconnect, NUM_TEAMS team blocks, LA and GPIO control
// One outstanding transaction at a time; mapped accesses ack after one cycle
// Write enable and write data fan out to every slave unchanged

`timescale 1ns/1ps

module team_top
    import team_pkg::*;
#(
    parameter int NUM_TEAMS = 3
) (
    input  logic      wb_clk_i,
    input  logic      rst_i,

    // Management Wishbone
    input  logic      wbs_stb_i,
    input  logic      wbs_we_i,
    input  wb_addr_t  wbs_adr_i,
    input  wb_data_t  wbs_dat_i,
    output logic      wbs_ack_o,
    output wb_data_t  wbs_dat_o,

    // Chip outputs
    output la_bus_t   la_data_o,
    output gpio_bus_t gpio_o
);

    logic [NUM_TEAMS:1] designs_stb;
    logic [NUM_TEAMS:1] designs_ack;
    wb_data_t           designs_dat [NUM_TEAMS:1];
    logic               la_control_stb;
    logic               la_control_ack;
    wb_data_t           la_control_dat;
    logic               gpio_control_stb;
    logic               gpio_control_ack;
    wb_data_t           gpio_control_dat;
    wb_addr_t           adr_trunc;
    la_bus_t            team_la [NUM_TEAMS:1];
    gpio_bus_t          team_gpio [NUM_TEAMS:1];

    wb_interconnect #(
        .NUM_TEAMS (NUM_TEAMS)
    ) u_interconnect (
        .wbs_stb_i     (wbs_stb_i),
        .wbs_adr_i     (wbs_adr_i),
        .wbs_ack_o     (wbs_ack_o),
        .wbs_dat_o     (wbs_dat_o),
        .designs_stb_o (designs_stb),
        .la_stb_o      (la_control_stb),
        .gpio_stb_o    (gpio_control_stb),
        .adr_trunc_o   (adr_trunc),
        .designs_dat_i (designs_dat),
        .designs_ack_i (designs_ack),
        .la_dat_i      (la_control_dat),
        .la_ack_i      (la_control_ack),
        .gpio_dat_i    (gpio_control_dat),
        .gpio_ack_i    (gpio_control_ack)
    );

    // Team N lives on page 0x30NN
    for (genvar g = 1; g <= NUM_TEAMS; g++) begin : g_team
        team_design #(
            .TEAM_ID (team_idx_t'(g))
        ) u_team (
            .wb_clk_i  (wb_clk_i),
            .rst_i     (rst_i),
            .stb_i     (designs_stb[g]),
            .we_i      (wbs_we_i),
            .adr_i     (adr_trunc),
            .dat_i     (wbs_dat_i),
            .ack_o     (designs_ack[g]),
            .dat_o     (designs_dat[g]),
            .la_data_o (team_la[g]),
            .gpio_o    (team_gpio[g])
        );
    end

    la_control #(
        .NUM_TEAMS (NUM_TEAMS)
    ) u_la_control (
        .wb_clk_i  (wb_clk_i),
        .rst_i     (rst_i),
        .stb_i     (la_control_stb),
        .we_i      (wbs_we_i),
        .adr_i     (adr_trunc),
        .dat_i     (wbs_dat_i),
        .ack_o     (la_control_ack),
        .dat_o     (la_control_dat),
        .team_la_i (team_la),
        .la_data_o (la_data_o)
    );

    gpio_control #(
        .NUM_TEAMS (NUM_TEAMS)
    ) u_gpio_control (
        .wb_clk_i    (wb_clk_i),
        .rst_i       (rst_i),
        .stb_i       (gpio_control_stb),
        .we_i        (wbs_we_i),
        .adr_i       (adr_trunc),
        .dat_i       (wbs_dat_i),
        .ack_o       (gpio_control_ack),
        .dat_o       (gpio_control_dat),
        .team_gpio_i (team_gpio),
        .gpio_o      (gpio_o)
    );

endmodule

//--- design/wb_interconnect.sv
// Purely combinational page decoder for the management Wishbone bus
// Unmapped pages and team numbers 0 or above NUM_TEAMS get no ack and zero data
// The master must time out such accesses on its own

`timescale 1ns/1ps

module wb_interconnect
    import team_pkg::*;
#(
    parameter int NUM_TEAMS = 3
) (
    // Master side
    input  logic      wbs_stb_i,
    input  wb_addr_t  wbs_adr_i,
    output logic      wbs_ack_o,
    output wb_data_t  wbs_dat_o,

    // Strobes towards the slaves
    output logic [NUM_TEAMS:1] designs_stb_o,
    output logic               la_stb_o,
    output logic               gpio_stb_o,

    // Slaves only see the page offset
    output wb_addr_t adr_trunc_o,

    // Slave responses
    input  wb_data_t           designs_dat_i [NUM_TEAMS:1],
    input  logic [NUM_TEAMS:1] designs_ack_i,
    input  wb_data_t           la_dat_i,
    input  logic               la_ack_i,
    input  wb_data_t           gpio_dat_i,
    input  logic               gpio_ack_i
);

    logic [15:0] page;
    team_idx_t   team_sel;
    logic        team_page;

    assign page      = wbs_adr_i[31:16];
    assign team_sel  = wbs_adr_i[23:16];
    assign team_page = (wbs_adr_i[31:24] == DESIGN_PREFIX);

    assign adr_trunc_o = {16'h0000, wbs_adr_i[15:0]};

    // Control blocks sit on fixed pages
    assign la_stb_o   = (page == LA_PAGE)   ? wbs_stb_i : 1'b0;
    assign gpio_stb_o = (page == GPIO_PAGE) ? wbs_stb_i : 1'b0;

    // One strobe per team, page 0x30NN
    always_comb begin
        for (int i = 1; i <= NUM_TEAMS; i++) begin
            designs_stb_o[i] = (team_page && team_sel == team_idx_t'(i)) ? wbs_stb_i : 1'b0;
        end
    end

    // Return path, zero by default
    always_comb begin
        wbs_dat_o = '0;
        wbs_ack_o = 1'b0;
        if (team_page) begin
            for (int i = 1; i <= NUM_TEAMS; i++) begin
                if (team_sel == team_idx_t'(i)) begin
                    wbs_dat_o = designs_dat_i[i];
                    wbs_ack_o = designs_ack_i[i];
                end
            end
        end else if (page == LA_PAGE) begin
            wbs_dat_o = la_dat_i;
            wbs_ack_o = la_ack_i;
        end else if (page == GPIO_PAGE) begin
            wbs_dat_o = gpio_dat_i;
            wbs_ack_o = gpio_ack_i;
        end
    end

endmodule

//--- team_top.f
design/team_pkg.sv
design/wb_interconnect.sv
design/team_design.sv
design/la_control.sv
design/gpio_control.sv
design/team_top.sv
testbench/team_top_checker.sv
testbench/team_top_tb.sv

//--- testbench/team_top_checker.sv
// Wishbone protocol assertions, bound into team_top
// Ack may stay high for the half cycle after the master drops strobe,
// so the strobe check samples on the falling edge

`timescale 1ns/1ps

module team_top_checker #(
    parameter int NUM_TEAMS = 3
) (
    input logic               wb_clk_i,
    input logic               rst_i,
    input logic               wbs_stb_i,
    input logic               wbs_ack_i,
    input logic [NUM_TEAMS:1] designs_stb_i,
    input logic               la_stb_i,
    input logic               gpio_stb_i,
    input logic [NUM_TEAMS:1] designs_ack_i,
    input logic               la_ack_i,
    input logic               gpio_ack_i
);

    // Number of assertion failures so far
    int fail_count = 0;

    // Single-cycle ack
    assert property (@(posedge wb_clk_i) disable iff (rst_i) wbs_ack_i |=> !wbs_ack_i)
        else begin
            fail_count++;
            $error("wbs_ack_o high for two consecutive cycles");
        end

    // Master holds strobe until it has seen ack
    assert property (@(negedge wb_clk_i) disable iff (rst_i) wbs_ack_i |-> wbs_stb_i)
        else begin
            fail_count++;
            $error("wbs_ack_o high without wbs_stb_i");
        end

    // Only one slave addressed at a time
    assert property (@(posedge wb_clk_i) $onehot0({designs_stb_i, la_stb_i, gpio_stb_i}))
        else begin
            fail_count++;
            $error("more than one slave strobe active");
        end

    // Every ack cleared by reset
    assert property (@(posedge wb_clk_i)
            rst_i |=> !(|designs_ack_i) && !la_ack_i && !gpio_ack_i && !wbs_ack_i)
        else begin
            fail_count++;
            $error("ack high during reset");
        end

endmodule

//--- testbench/team_top_tb.sv
// Testbench for team_top with three teams
// Counter values are only predicted while a counter is stopped
// Inputs change on the falling edge, bus data is compared on the rising edge

`timescale 1ns/1ps

module team_top_tb
    import team_pkg::*;
#(
    parameter int NUM_TEAMS = 3
) ();

    localparam int ACK_LIMIT      = 8;
    localparam int TIMEOUT_CYCLES = 4000;

    logic      wb_clk_i;
    logic      rst_i;
    logic      wbs_stb_i;
    logic      wbs_we_i;
    wb_addr_t  wbs_adr_i;
    wb_data_t  wbs_dat_i;
    logic      wbs_ack_o;
    wb_data_t  wbs_dat_o;
    la_bus_t   la_data_o;
    gpio_bus_t gpio_o;

    // Reference model state
    wb_data_t  scratch_ref [1:NUM_TEAMS];
    wb_data_t  ctrl_ref [1:NUM_TEAMS];
    wb_data_t  count_ref [1:NUM_TEAMS];
    team_idx_t la_sel_ref;
    team_idx_t owner_ref;
    gpio_bus_t mask_ref;
    gpio_bus_t value_ref;

    integer    seed = 32'h5de0;
    int        errors;
    int        checks;
    int        cycles;
    int        ack_wait;
    logic      check_read;
    wb_data_t  exp_data;

    team_top #(
        .NUM_TEAMS (NUM_TEAMS)
    ) u_team_top (
        .wb_clk_i  (wb_clk_i),
        .rst_i     (rst_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o),
        .la_data_o (la_data_o),
        .gpio_o    (gpio_o)
    );

    bind team_top team_top_checker #(
        .NUM_TEAMS (NUM_TEAMS)
    ) u_checker (
        .wb_clk_i      (wb_clk_i),
        .rst_i         (rst_i),
        .wbs_stb_i     (wbs_stb_i),
        .wbs_ack_i     (wbs_ack_o),
        .designs_stb_i (designs_stb),
        .la_stb_i      (la_control_stb),
        .gpio_stb_i    (gpio_control_stb),
        .designs_ack_i (designs_ack),
        .la_ack_i      (la_control_ack),
        .gpio_ack_i    (gpio_control_ack)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #5 wb_clk_i = ~wb_clk_i;
    end

    function automatic wb_addr_t team_address(input int t, input logic [15:0] off);
        team_address = {DESIGN_PREFIX, 8'(t), off};
    endfunction

    function automatic logic valid_team(input team_idx_t t);
        valid_team = (t >= 1) && (t <= NUM_TEAMS);
    endfunction

    // Selected team's counter, zero without a valid select
    function automatic la_bus_t expected_la();
        expected_la = valid_team(la_sel_ref) ? count_ref[la_sel_ref] : '0;
    endfunction

    // Pin by pin: forced value where the mask is set, else the owner's pin
    function automatic gpio_bus_t expected_gpio();
        gpio_bus_t pins;
        pins = valid_team(owner_ref) ? scratch_ref[owner_ref][15:0] : '0;
        for (int i = 0; i < 16; i++) begin
            expected_gpio[i] = mask_ref[i] ? value_ref[i] : pins[i];
        end
    endfunction

    function automatic wb_data_t expected_read(input wb_addr_t adr);
        team_idx_t t;
        t = adr[23:16];
        expected_read = '0;
        if (adr[31:24] == DESIGN_PREFIX && valid_team(t)) begin
            case (adr[15:0])
                REG_SCRATCH: expected_read = scratch_ref[t];
                REG_CTRL:    expected_read = ctrl_ref[t];
                REG_COUNT:   expected_read = count_ref[t];
                REG_ID:      expected_read = {24'h000000, t};
                default:     ;
            endcase
        end else if (adr[31:16] == LA_PAGE) begin
            case (adr[15:0])
                REG_LA_SEL:  expected_read = {24'h000000, la_sel_ref};
                REG_LA_SNAP: expected_read = expected_la();
                default:     ;
            endcase
        end else if (adr[31:16] == GPIO_PAGE) begin
            case (adr[15:0])
                REG_GPIO_OWNER: expected_read = {24'h000000, owner_ref};
                REG_GPIO_MASK:  expected_read = {16'h0000, mask_ref};
                REG_GPIO_VALUE: expected_read = {16'h0000, value_ref};
                default:        ;
            endcase
        end
    endfunction

    // Shadow update for an acknowledged write
    task automatic apply_write(input wb_addr_t adr, input wb_data_t dat);
        team_idx_t t;
        t = adr[23:16];
        if (adr[31:24] == DESIGN_PREFIX && valid_team(t)) begin
            case (adr[15:0])
                REG_SCRATCH: scratch_ref[t] = dat;
                REG_CTRL:    ctrl_ref[t] = dat;
                default:     ;
            endcase
        end else if (adr[31:16] == LA_PAGE && adr[15:0] == REG_LA_SEL) begin
            la_sel_ref = dat[7:0];
        end else if (adr[31:16] == GPIO_PAGE) begin
            case (adr[15:0])
                REG_GPIO_OWNER: owner_ref = dat[7:0];
                REG_GPIO_MASK:  mask_ref = dat[15:0];
                REG_GPIO_VALUE: value_ref = dat[15:0];
                default:        ;
            endcase
        end
    endtask

    task automatic report_mismatch(input string name, input wb_data_t exp, input wb_data_t got);
        errors++;
        $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
    endtask

    // Holds strobe from the current falling edge until ack or the limit
    task automatic run_cycle(input wb_addr_t adr, input logic we, input wb_data_t dat,
                             output wb_data_t rdata, output logic acked);
        int n;
        n = 0;
        acked = 1'b0;
        rdata = '0;
        wbs_adr_i = adr;
        wbs_we_i  = we;
        wbs_dat_i = dat;
        wbs_stb_i = 1'b1;
        while (!acked && n < ACK_LIMIT) begin
            @(negedge wb_clk_i);
            n++;
            rdata = wbs_dat_o;
            acked = wbs_ack_o;
        end
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        ack_wait  = n;
        if (acked) begin
            checks++;
            if (n != 1) begin
                report_mismatch("ack latency", 32'd1, n);
            end
        end
    endtask

    task automatic bus_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        logic     acked;
        @(negedge wb_clk_i);
        check_read = 1'b0;
        run_cycle(adr, 1'b1, dat, unused, acked);
        if (acked) begin
            apply_write(adr, dat);
        end else begin
            errors++;
            $display("ERROR t=%0t: write to %h was never acknowledged", $time, adr);
        end
    endtask

    task automatic bus_read(input wb_addr_t adr, input logic check, output wb_data_t data);
        logic acked;
        @(negedge wb_clk_i);
        check_read = check;
        exp_data   = expected_read(adr);
        run_cycle(adr, 1'b0, '0, data, acked);
        if (!acked) begin
            errors++;
            $display("ERROR t=%0t: read from %h was never acknowledged", $time, adr);
        end
    endtask

    task automatic bus_probe_unmapped(input wb_addr_t adr);
        wb_data_t data;
        logic     acked;
        @(negedge wb_clk_i);
        check_read = 1'b0;
        run_cycle(adr, 1'b0, '0, data, acked);
        checks++;
        if (acked) begin
            errors++;
            $display("ERROR t=%0t: unmapped address %h was acknowledged", $time, adr);
        end
        if (data !== '0) begin
            report_mismatch("wbs_dat_o", '0, data);
        end
    endtask

    task automatic check_outputs();
        checks++;
        if (la_data_o !== expected_la()) begin
            report_mismatch("la_data_o", expected_la(), la_data_o);
        end
        if (gpio_o !== expected_gpio()) begin
            report_mismatch("gpio_o", expected_gpio(), gpio_o);
        end
    endtask

    // Compares read data while ack is high
    always @(posedge wb_clk_i) begin
        if (!rst_i && wbs_ack_o && check_read) begin
            checks++;
            if (wbs_dat_o !== exp_data) begin
                report_mismatch("wbs_dat_o", exp_data, wbs_dat_o);
            end
        end
    end

    always @(posedge wb_clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Summary: %0d errors in %0d checks", errors, checks);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        wb_data_t  d;
        wb_data_t  snap;
        wb_data_t  diff;
        la_bus_t   la_prev;
        gpio_bus_t gpio_prev;
        int        count_start;
        rst_i      = 1'b1;
        wbs_stb_i  = 1'b0;
        wbs_we_i   = 1'b0;
        wbs_adr_i  = '0;
        wbs_dat_i  = '0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        ack_wait   = 0;
        check_read = 1'b0;
        exp_data   = '0;
        la_sel_ref = '0;
        owner_ref  = '0;
        mask_ref   = '0;
        value_ref  = '0;
        for (int t = 1; t <= NUM_TEAMS; t++) begin
            scratch_ref[t] = '0;
            ctrl_ref[t]    = '0;
            count_ref[t]   = '0;
        end
        repeat (10) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        rst_i = 1'b0;

        // Reset state and team identifiers
        check_outputs();
        for (int t = 1; t <= NUM_TEAMS; t++) begin
            bus_read(team_address(t, REG_ID), 1'b1, d);
        end

        // Scratch readback, ID is read-only
        for (int t = 1; t <= NUM_TEAMS; t++) begin
            bus_write(team_address(t, REG_SCRATCH), $random(seed));
            bus_read(team_address(t, REG_SCRATCH), 1'b1, d);
            bus_write(team_address(t, REG_ID), $random(seed));
            bus_read(team_address(t, REG_ID), 1'b1, d);
        end

        // Team 0, team above range, unmapped page
        bus_probe_unmapped(32'h3000_0000);
        bus_probe_unmapped(32'h3004_0000);
        bus_probe_unmapped(32'h3300_0000);

        // LA path with team 2 counting
        bus_write({LA_PAGE, REG_LA_SEL}, 32'd2);
        check_outputs();
        bus_write(team_address(2, REG_CTRL), 32'd1);
        count_start = cycles;
        @(negedge wb_clk_i);
        la_prev = la_data_o;
        @(negedge wb_clk_i);
        checks++;
        if (la_prev == '0 || la_data_o <= la_prev) begin
            errors++;
            $display("ERROR t=%0t: la_data_o is not a nonzero rising count", $time);
        end
        bus_read({LA_PAGE, REG_LA_SNAP}, 1'b0, snap);
        diff = la_data_o - snap;
        checks++;
        if (diff < 1 || diff > ack_wait) begin
            errors++;
            $display("ERROR t=%0t: snapshot lags la_data_o by %0d counts", $time, diff);
        end
        bus_write(team_address(2, REG_CTRL), 32'd0);
        // One count per edge after the enable ack, up to and including the disable ack
        count_ref[2] = cycles - count_start;
        @(negedge wb_clk_i);
        bus_read(team_address(2, REG_COUNT), 1'b1, d);
        check_outputs();
        bus_read({LA_PAGE, REG_LA_SNAP}, 1'b1, snap);
        bus_write({LA_PAGE, REG_LA_SEL}, 32'd0);
        check_outputs();
        // Upper bits dropped, select 5 is out of range
        bus_write({LA_PAGE, REG_LA_SEL}, 32'h0000_0105);
        bus_read({LA_PAGE, REG_LA_SEL}, 1'b1, d);
        check_outputs();

        // GPIO owner and forcing, owner walks 2, 3, 0, 1
        bus_write({GPIO_PAGE, REG_GPIO_OWNER}, 32'd1);
        check_outputs();
        for (int r = 0; r < 4; r++) begin
            bus_write({GPIO_PAGE, REG_GPIO_MASK}, $random(seed));
            bus_write({GPIO_PAGE, REG_GPIO_VALUE}, $random(seed));
            check_outputs();
            gpio_prev = gpio_o;
            bus_write({GPIO_PAGE, REG_GPIO_OWNER}, (r + 2) % (NUM_TEAMS + 1));
            check_outputs();
            checks++;
            if (((gpio_prev ^ gpio_o) & mask_ref) != '0) begin
                errors++;
                $display("ERROR t=%0t: a forced GPIO pin changed with the owner", $time);
            end
            bus_read({GPIO_PAGE, REG_GPIO_MASK}, 1'b1, d);
            bus_read({GPIO_PAGE, REG_GPIO_VALUE}, 1'b1, d);
        end
        bus_read({GPIO_PAGE, REG_GPIO_OWNER}, 1'b1, d);

        @(negedge wb_clk_i);
        errors += u_team_top.u_checker.fail_count;
        $display("Summary: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
